// File: source/agc_bus_pkg.sv
package agc_bus_pkg;

    localparam int BUS_ADDR_W = 8;
    localparam int BUS_DATA_W = 32;

    // Master side of a Wishbone-style bus
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [BUS_ADDR_W-1:0]   adr;
        logic [BUS_DATA_W-1:0]   dat;
        logic [BUS_DATA_W/8-1:0] sel;
    } bus_req_t;

    typedef struct packed {
        logic                  ack;
        logic [BUS_DATA_W-1:0] dat;
    } bus_rsp_t;

    // One-cycle request from the sequencer to the bus master
    typedef struct packed {
        logic                  valid;
        logic                  we;
        logic [BUS_ADDR_W-1:0] adr;
        logic [BUS_DATA_W-1:0] dat;
    } xfer_req_t;

endpackage

// File: source/agc_loop_pkg.sv
package agc_loop_pkg;

    // Downstream AGC register map
    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_SCALE  = 8'h10;
    localparam logic [7:0] ADDR_OFFSET = 8'h14;

    // Control words written to ADDR_CTRL
    localparam logic [31:0] CMD_START = 32'h0000_0001;
    localparam logic [31:0] CMD_RESET = 32'h0000_0004;  // Clear statistics
    localparam logic [31:0] CMD_LOAD  = 32'h0000_0300;  // Load scale and offset
    localparam logic [31:0] CMD_APPLY = 32'h0000_0400;

    // Control/status register fields
    typedef struct packed {
        logic [20:0] rsvd_hi;
        logic        apply;
        logic [1:0]  load;
        logic [4:0]  rsvd_lo;
        logic        reset;
        logic        done;     // Sample period finished, read side only
        logic        start;
    } agc_ctrl_t;

    typedef union packed {
        logic [31:0] raw;
        agc_ctrl_t   ctrl;
    } agc_word_u;

    typedef enum logic [3:0] {
        BOOT, WRITE_SCALE, WRITE_OFFSET, LOAD, APPLY,
        RESET, START, POLL, READ_INFO, CALC
    } seq_state_e;

    localparam int SCALE_W  = 17;
    localparam int OFFSET_W = 16;

    localparam logic [SCALE_W-1:0]  START_SCALE   = 17'd1800;
    localparam logic [OFFSET_W-1:0] START_OFFSET  = 16'd0;
    localparam logic [SCALE_W-1:0]  SCALE_MIN_CUT = 17'h0012C;
    localparam logic [SCALE_W-1:0]  SCALE_MAX_CUT = 17'h1FBD0;

    localparam int N_INFO = 6;
    typedef logic [N_INFO-1:0][31:0] info_bank_t;  // Status words read back each cycle

endpackage

// File: source/agc_bus_master.sv
module agc_bus_master (
    input  logic                                  aclk,
    input  logic                                  wb_rst_i,
    input  logic                                  agc_reset_i,
    input  agc_bus_pkg::xfer_req_t                req_i,
    input  agc_bus_pkg::bus_rsp_t                 bus_rsp_i,
    output agc_bus_pkg::bus_req_t                 bus_req_o,
    output logic                                  done_o,
    output logic [agc_bus_pkg::BUS_DATA_W-1:0]    rdata_o
);
    import agc_bus_pkg::*;

    bus_req_t issue_req;
    logic     ack_seen;

    assign ack_seen = bus_req_o.cyc && bus_rsp_i.ack;

    // Bus word for a new request, cyc and stb rise together
    always_comb begin
        issue_req     = '0;
        issue_req.cyc = 1'b1;
        issue_req.stb = 1'b1;
        issue_req.we  = req_i.we;
        issue_req.adr = req_i.adr;
        issue_req.dat = req_i.dat;
        issue_req.sel = '1;
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            bus_req_o <= '0;
            done_o    <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (ack_seen) begin
                bus_req_o <= '0;     // Release the bus on the ack edge
                done_o    <= 1'b1;
            end else if (req_i.valid) begin
                bus_req_o <= issue_req;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ack_seen) begin
            rdata_o <= bus_rsp_i.dat;  // Meaningful on reads only
        end
    end

    // The sequencer waits for done before it asks again
    a_no_req_while_open: assert property (
        @(posedge aclk) disable iff (wb_rst_i || agc_reset_i)
        req_i.valid |-> !bus_req_o.cyc
    ) else $error("request issued while a downstream transaction is open");

endmodule

// File: source/agc_sequencer.sv
module agc_sequencer #(
    parameter int BOOT_CYCLES = 31
) (
    input  logic                                  aclk,
    input  logic                                  wb_rst_i,
    input  logic                                  agc_reset_i,
    input  logic                                  done_i,
    input  logic [agc_bus_pkg::BUS_DATA_W-1:0]    rdata_i,
    input  logic [agc_loop_pkg::SCALE_W-1:0]      new_scale_i,
    input  logic [agc_loop_pkg::OFFSET_W-1:0]     new_offset_i,
    output agc_bus_pkg::xfer_req_t                req_o,
    output agc_loop_pkg::info_bank_t              info_o
);
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    localparam int CNT_W = $clog2(BOOT_CYCLES + 2);

    seq_state_e            state;
    logic                  busy;          // Downstream transaction open
    logic [CNT_W-1:0]      boot_cnt;
    logic [2:0]            info_idx;
    logic [SCALE_W-1:0]    scale_q;
    logic [OFFSET_W-1:0]   offset_q;
    logic [BUS_DATA_W-1:0] scale_word;
    logic [BUS_DATA_W-1:0] offset_word;
    logic                  issue;
    agc_word_u             status;

    assign scale_word  = {{(BUS_DATA_W-SCALE_W){1'b0}}, scale_q};
    assign offset_word = {{(BUS_DATA_W-OFFSET_W){offset_q[OFFSET_W-1]}}, offset_q};
    assign status.raw  = rdata_i;
    assign issue       = !busy && (state != BOOT) && (state != CALC);

    ////////////////////////////////////////
    // Request for the current phase
    ////////////////////////////////////////
    always_comb begin
        req_o = '0;
        unique case (state)
            WRITE_SCALE:  req_o = '{valid: issue, we: 1'b1, adr: ADDR_SCALE, dat: scale_word};
            WRITE_OFFSET: req_o = '{valid: issue, we: 1'b1, adr: ADDR_OFFSET, dat: offset_word};
            LOAD:         req_o = '{valid: issue, we: 1'b1, adr: ADDR_CTRL, dat: CMD_LOAD};
            APPLY:        req_o = '{valid: issue, we: 1'b1, adr: ADDR_CTRL, dat: CMD_APPLY};
            RESET:        req_o = '{valid: issue, we: 1'b1, adr: ADDR_CTRL, dat: CMD_RESET};
            START:        req_o = '{valid: issue, we: 1'b1, adr: ADDR_CTRL, dat: CMD_START};
            POLL:         req_o = '{valid: issue, we: 1'b0, adr: ADDR_CTRL, dat: '0};
            READ_INFO: begin
                req_o.valid = issue;
                req_o.adr   = BUS_ADDR_W'({info_idx, 2'b00});  // Word addresses 0 to 0x14
            end
            default: req_o = '0;
        endcase
    end

    ////////////////////////////////////////
    // Phase sequencing and status store
    ////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (wb_rst_i || agc_reset_i) begin
            state    <= BOOT;
            busy     <= 1'b0;
            boot_cnt <= CNT_W'(BOOT_CYCLES);
            info_idx <= '0;
            scale_q  <= START_SCALE;
            offset_q <= START_OFFSET;
            info_o   <= '0;
        end else begin
            if (req_o.valid) begin
                busy <= 1'b1;
            end else if (done_i) begin
                busy <= 1'b0;
            end
            unique case (state)
                BOOT: begin
                    if (boot_cnt != '0) boot_cnt <= boot_cnt - 1'b1;
                    else state <= WRITE_SCALE;
                end
                WRITE_SCALE:  if (done_i) state <= WRITE_OFFSET;
                WRITE_OFFSET: if (done_i) state <= LOAD;
                LOAD:         if (done_i) state <= APPLY;
                APPLY: begin
                    if (done_i) begin
                        info_o[4] <= scale_word;   // Values now live downstream
                        info_o[5] <= offset_word;
                        state     <= RESET;
                    end
                end
                RESET:        if (done_i) state <= START;
                START:        if (done_i) state <= POLL;
                POLL:         if (done_i && status.ctrl.done) state <= READ_INFO;
                READ_INFO: begin
                    if (done_i) begin
                        info_o[info_idx] <= rdata_i;
                        info_idx         <= info_idx + 1'b1;
                        if (info_idx == 3'(N_INFO - 1)) state <= CALC;
                    end
                end
                CALC: begin
                    scale_q  <= new_scale_i;
                    offset_q <= new_offset_i;
                    info_idx <= '0;
                    state    <= WRITE_SCALE;
                end
                default: state <= BOOT;
            endcase
        end
    end

    a_state_legal: assert property (
        @(posedge aclk) disable iff (wb_rst_i)
        state inside {BOOT, WRITE_SCALE, WRITE_OFFSET, LOAD, APPLY,
                      RESET, START, POLL, READ_INFO, CALC}
    ) else $error("sequencer left its state set");

endmodule

// File: source/agc_update_calc.sv
module agc_update_calc #(
    parameter int TARGET_RMS_SQUARED       = 16,
    parameter int RMS_SQUARE_SCALE_ERR     = 0,
    parameter int OFFSET_ERR               = 5,
    parameter int SCALE_DELTA              = 30,
    parameter int OFFSET_DELTA             = 25,
    parameter int TIMESCALE_REDUCTION_BITS = 4
) (
    input  agc_loop_pkg::info_bank_t              info_i,
    input  logic [agc_loop_pkg::SCALE_W-1:0]      prev_scale_i,
    input  logic [agc_loop_pkg::OFFSET_W-1:0]     prev_offset_i,
    output logic [agc_loop_pkg::SCALE_W-1:0]      new_scale_o,
    output logic [agc_loop_pkg::OFFSET_W-1:0]     new_offset_o
);
    import agc_loop_pkg::*;

    localparam int          MS_SHIFT = 17 - TIMESCALE_REDUCTION_BITS;
    localparam logic [25:0] MS_HIGH  = 26'(TARGET_RMS_SQUARED + RMS_SQUARE_SCALE_ERR);
    localparam logic [25:0] MS_LOW   = 26'(TARGET_RMS_SQUARED - RMS_SQUARE_SCALE_ERR);

    logic [24:0]         mean_sq;
    logic [SCALE_W-1:0]  word4_scale;
    logic [OFFSET_W-1:0] word5_offset;
    logic [32:0]         above_plus_err;   // Extra bit keeps the sum from wrapping
    logic [32:0]         below_plus_err;

    assign mean_sq        = info_i[1][24:0] >> MS_SHIFT;
    assign word4_scale    = info_i[4][SCALE_W-1:0];
    assign word5_offset   = info_i[5][OFFSET_W-1:0];
    assign above_plus_err = {1'b0, info_i[2]} + 33'(OFFSET_ERR);
    assign below_plus_err = {1'b0, info_i[3]} + 33'(OFFSET_ERR);

    // Scale follows the mean-square estimate, clamped near the cuts
    always_comb begin
        new_scale_o = prev_scale_i;
        if ({1'b0, mean_sq} > MS_HIGH) begin
            if (info_i[4] > SCALE_MIN_CUT) new_scale_o = word4_scale - SCALE_W'(SCALE_DELTA);
            else new_scale_o = word4_scale;
        end else if ({1'b0, mean_sq} < MS_LOW) begin
            if (info_i[4] < SCALE_MAX_CUT) new_scale_o = word4_scale + SCALE_W'(SCALE_DELTA);
            else new_scale_o = word4_scale;
        end
    end

    // Offset balances the above and below counts
    always_comb begin
        new_offset_o = prev_offset_i;
        if ({1'b0, info_i[2]} > below_plus_err) begin
            new_offset_o = word5_offset - OFFSET_W'(OFFSET_DELTA);
        end else if ({1'b0, info_i[3]} > above_plus_err) begin
            new_offset_o = word5_offset + OFFSET_W'(OFFSET_DELTA);
        end
    end

endmodule

// File: source/agc_status_target.sv
module agc_status_target #(
    parameter int SCALE_DELTA  = 30,
    parameter int OFFSET_DELTA = 25
) (
    input  logic                     aclk,
    input  logic                     wb_rst_i,
    input  agc_bus_pkg::bus_req_t    host_req_i,
    input  agc_loop_pkg::info_bank_t info_i,
    output agc_bus_pkg::bus_rsp_t    host_rsp_o
);
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    typedef enum logic [1:0] {IDLE, READ, WRITE, ACK} tgt_state_e;

    localparam logic [SCALE_W-1:0]  SCALE_STEP  = SCALE_W'(SCALE_DELTA);
    localparam logic [OFFSET_W-1:0] OFFSET_STEP = OFFSET_W'(OFFSET_DELTA);

    tgt_state_e            state;
    logic [3:0]            word_sel;
    logic [BUS_DATA_W-1:0] rd_data;
    logic [BUS_DATA_W-1:0] resp_q;

    assign word_sel = host_req_i.adr[5:2];

    // Address bit 6 picks the loop registers over the status store
    always_comb begin
        rd_data = '0;
        if (host_req_i.adr[6]) begin
            case (word_sel)
                4'd0:    rd_data = {{(BUS_DATA_W-SCALE_W){1'b0}}, SCALE_STEP};
                4'd1:    rd_data = {{(BUS_DATA_W-OFFSET_W){OFFSET_STEP[OFFSET_W-1]}}, OFFSET_STEP};
                default: rd_data = '0;
            endcase
        end else if (word_sel < 4'(N_INFO)) begin
            rd_data = info_i[word_sel[2:0]];
        end
    end

    always_ff @(posedge aclk) begin
        if (wb_rst_i) begin
            state <= IDLE;
        end else begin
            unique case (state)
                IDLE: begin
                    if (host_req_i.cyc && host_req_i.stb) begin
                        state <= host_req_i.we ? WRITE : READ;
                    end
                end
                READ:    state <= ACK;
                WRITE:   state <= ACK;   // No writable registers here
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == READ) resp_q <= rd_data;
    end

    assign host_rsp_o.ack = (state == ACK);
    assign host_rsp_o.dat = resp_q;

    a_ack_single: assert property (
        @(posedge aclk) disable iff (wb_rst_i)
        host_rsp_o.ack |=> !host_rsp_o.ack
    ) else $error("host ack held for more than one cycle");

endmodule

// File: source/agc_loop_top.sv
module agc_loop_top #(
    parameter int TARGET_RMS_SQUARED       = 16,
    parameter int RMS_SQUARE_SCALE_ERR     = 0,
    parameter int OFFSET_ERR               = 5,
    parameter int SCALE_DELTA              = 30,
    parameter int OFFSET_DELTA             = 25,
    parameter int TIMESCALE_REDUCTION_BITS = 4,
    parameter int BOOT_CYCLES              = 31
) (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  logic                  agc_reset_i,
    output agc_bus_pkg::bus_req_t agc_req_o,
    input  agc_bus_pkg::bus_rsp_t agc_rsp_i,
    input  agc_bus_pkg::bus_req_t host_req_i,
    output agc_bus_pkg::bus_rsp_t host_rsp_o
);
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    xfer_req_t             seq_req;
    logic                  xfer_done;
    logic [BUS_DATA_W-1:0] xfer_rdata;
    info_bank_t            info_bank;
    logic [SCALE_W-1:0]    new_scale;
    logic [OFFSET_W-1:0]   new_offset;

    agc_sequencer #(.BOOT_CYCLES(BOOT_CYCLES)) u_sequencer (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .done_i(xfer_done), .rdata_i(xfer_rdata),
        .new_scale_i(new_scale), .new_offset_i(new_offset),
        .req_o(seq_req), .info_o(info_bank)
    );

    agc_bus_master u_bus_master (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .req_i(seq_req), .bus_rsp_i(agc_rsp_i), .bus_req_o(agc_req_o),
        .done_o(xfer_done), .rdata_o(xfer_rdata)
    );

    // Previous scale and offset come back as status words 4 and 5
    agc_update_calc #(
        .TARGET_RMS_SQUARED(TARGET_RMS_SQUARED), .RMS_SQUARE_SCALE_ERR(RMS_SQUARE_SCALE_ERR),
        .OFFSET_ERR(OFFSET_ERR), .SCALE_DELTA(SCALE_DELTA), .OFFSET_DELTA(OFFSET_DELTA),
        .TIMESCALE_REDUCTION_BITS(TIMESCALE_REDUCTION_BITS)
    ) u_update_calc (
        .info_i(info_bank),
        .prev_scale_i(info_bank[4][SCALE_W-1:0]), .prev_offset_i(info_bank[5][OFFSET_W-1:0]),
        .new_scale_o(new_scale), .new_offset_o(new_offset)
    );

    agc_status_target #(.SCALE_DELTA(SCALE_DELTA), .OFFSET_DELTA(OFFSET_DELTA)) u_status_target (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .host_req_i(host_req_i),
        .info_i(info_bank), .host_rsp_o(host_rsp_o)
    );

endmodule

// File: sim/agc_loop_checker.sv
module agc_loop_checker (
    input  logic                  aclk,
    input  logic                  wb_rst_i,
    input  logic                  agc_reset_i,
    input  agc_bus_pkg::bus_req_t agc_req_i,
    input  agc_bus_pkg::bus_rsp_t agc_rsp_i,
    input  agc_bus_pkg::bus_req_t host_req_i,
    input  agc_bus_pkg::bus_rsp_t host_rsp_i,
    input  logic [16:0]           tbl_scale_i,   // Table row expectation
    input  logic [15:0]           tbl_offset_i,
    output int                    err_cnt_o,
    output int                    test_cnt_o,
    output int                    restart_writes_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    localparam int MS_SHIFT = 13;  // 17 minus the timescale reduction

    int          step = 0;
    int          idx = 0;
    int          host_cycles = 0;
    logic        host_track = 1'b0;
    logic [7:0]  host_adr = '0;
    logic        restarted = 1'b0;
    logic [16:0] exp_scale = 17'd1800;
    logic [15:0] exp_offset = 16'd0;
    logic [31:0] store [6] = '{default: '0};

    initial begin
        err_cnt_o = 0;
        test_cnt_o = 0;
        restart_writes_o = 0;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
            err_cnt_o++;
        end
    endtask

    // Scale rule applied to the mean-square word and the stored scale
    function automatic logic [16:0] rule_scale(input logic [31:0] w1, input logic [31:0] w4);
        logic [31:0] ms;
        ms = {7'd0, w1[24:0]} >> MS_SHIFT;
        if (ms > 32'd16) return (w4 > 32'h12C) ? w4[16:0] - 17'd30 : w4[16:0];
        if (ms < 32'd16) return (w4 < 32'h1FBD0) ? w4[16:0] + 17'd30 : w4[16:0];
        return w4[16:0];
    endfunction

    function automatic logic [15:0] rule_offset(input logic [31:0] w2, input logic [31:0] w3,
                                                input logic [31:0] w5);
        if ({1'b0, w2} > {1'b0, w3} + 33'd5) return w5[15:0] - 16'd25;
        if ({1'b0, w3} > {1'b0, w2} + 33'd5) return w5[15:0] + 16'd25;
        return w5[15:0];
    endfunction

    always @(posedge aclk) begin
        logic        exp_we;
        logic [7:0]  exp_adr;
        logic [31:0] exp_dat;
        logic [31:0] exp_host;
        agc_word_u   poll_word;
        ////////////////////////////////////////
        // Downstream transaction order
        ////////////////////////////////////////
        if (wb_rst_i || agc_reset_i) begin
            step = 0;
            idx = 0;
            exp_scale = START_SCALE;
            exp_offset = START_OFFSET;
            if (agc_reset_i) begin
                restarted = 1'b1;
                restart_writes_o = 0;
                store = '{default: '0};
            end
        end else if (agc_req_i.cyc && agc_rsp_i.ack) begin
            exp_we = 1'b1;
            exp_adr = ADDR_CTRL;
            exp_dat = '0;
            case (step)
                0: begin
                    exp_adr = ADDR_SCALE;
                    exp_dat = {15'd0, exp_scale};
                end
                1: begin
                    exp_adr = ADDR_OFFSET;
                    exp_dat = {{16{exp_offset[15]}}, exp_offset};  // Sign-extended
                end
                2: exp_dat = CMD_LOAD;
                3: exp_dat = CMD_APPLY;
                4: exp_dat = CMD_RESET;
                5: exp_dat = CMD_START;
                6: exp_we = 1'b0;
                default: begin
                    exp_we = 1'b0;
                    exp_adr = 8'(idx * 4);
                end
            endcase
            check("agc_req_o.stb", {31'd0, agc_req_i.stb}, 32'd1);
            check("agc_req_o.sel", {28'd0, agc_req_i.sel}, 32'hF);
            check("agc_req_o.we", {31'd0, agc_req_i.we}, {31'd0, exp_we});
            check("agc_req_o.adr", {24'd0, agc_req_i.adr}, {24'd0, exp_adr});
            if (exp_we) check("agc_req_o.dat", agc_req_i.dat, exp_dat);
            if (step == 3) begin
                store[4] = {15'd0, exp_scale};
                store[5] = {{16{exp_offset[15]}}, exp_offset};
            end
            if (step < 6) begin
                if (restarted && step < 4) begin
                    restart_writes_o++;
                    if (restart_writes_o == 4) begin
                        test_cnt_o++;
                        $display("restart after agc_reset_i finished, errors %0d", err_cnt_o);
                    end
                end
                step++;
            end else if (step == 6) begin
                poll_word.raw = agc_rsp_i.dat;
                if (poll_word.ctrl.done) step = 7;
            end else begin
                store[idx] = agc_rsp_i.dat;
                if (idx == 5) begin
                    exp_scale = rule_scale(store[1], store[4]);
                    exp_offset = rule_offset(store[2], store[3], store[5]);
                    check("tbl_scale_i", {15'd0, tbl_scale_i}, {15'd0, exp_scale});
                    check("tbl_offset_i", {16'd0, tbl_offset_i}, {16'd0, exp_offset});
                    test_cnt_o++;
                    $display("loop cycle %0d finished, errors %0d", test_cnt_o, err_cnt_o);
                    step = 0;
                    idx = 0;
                end else begin
                    idx++;
                end
            end
        end

        ////////////////////////////////////////
        // Host reads
        ////////////////////////////////////////
        if (wb_rst_i) begin
            host_track = 1'b0;
        end else if (host_track) begin
            host_cycles++;
            if (host_rsp_i.ack) begin
                if (host_adr[6]) begin
                    exp_host = (host_adr[5:2] == 4'd0) ? 32'd30 :
                               (host_adr[5:2] == 4'd1) ? 32'd25 : 32'd0;
                end else begin
                    exp_host = (host_adr[5:2] < 4'd6) ? store[host_adr[4:2]] : 32'd0;
                end
                if (host_cycles != 2) begin
                    $display("host ack came %0d cycles after the request instead of 2",
                             host_cycles);
                    err_cnt_o++;
                end
                check("host_rsp_o.dat", host_rsp_i.dat, exp_host);
                test_cnt_o++;
                $display("host read 0x%02h finished, errors %0d", host_adr, err_cnt_o);
                host_track = 1'b0;
            end
        end else if (host_req_i.cyc && host_req_i.stb) begin
            host_track = 1'b1;
            host_cycles = 0;
            host_adr = host_req_i.adr;
        end
    end

endmodule

// File: sim/tb_agc_loop.sv
module tb_agc_loop;
    timeunit 1ns;
    timeprecision 1ps;
    import agc_bus_pkg::*;
    import agc_loop_pkg::*;

    localparam int N_ROWS = 6;
    localparam int CLK_NS = 4;

    // Words 1 to 5 served downstream, then the scale and offset the loop should write next
    typedef struct packed {
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        logic [31:0] w4;
        logic [31:0] w5;
        logic [16:0] exp_scale;
        logic [15:0] exp_offset;
    } row_t;

    row_t rows [N_ROWS] = '{
        '{32'h40000, 32'd100, 32'd10, 32'd1800, 32'd0, 17'd1770, 16'hFFE7},  // Above band
        '{32'h01000, 32'd50, 32'd50, 32'd1770, 32'hFFFFFFE7, 17'd1800, 16'hFFE7},  // Below
        '{32'h20000, 32'd10, 32'd40, 32'd1800, 32'hFFFFFFE7, 17'd1800, 16'h0000},  // In band
        '{32'h40000, 32'd0, 32'd0, 32'h12C, 32'd0, 17'h12C, 16'h0000},  // At the low cut
        '{32'h00000, 32'd0, 32'd0, 32'h1FBD0, 32'd5, 17'h1FBD0, 16'h0005},  // At the high cut
        '{32'h40000, 32'd20, 32'd14, 32'h12D, 32'd5, 17'h10F, 16'hFFEC}
    };

    logic       aclk = 1'b0;
    logic       wb_rst_i = 1'b1;
    logic       agc_reset_i = 1'b0;
    bus_req_t   agc_req;
    bus_rsp_t   agc_rsp = '0;
    bus_req_t   host_req = '0;
    bus_rsp_t   host_rsp;
    int         seed = 24323;
    int         row = 0;
    int         row_c;
    int         wait_cnt = 0;
    int         polls_left = 0;
    int         start_cnt = 0;
    int         tb_errs = 0;
    int         err_cnt;
    int         test_cnt;
    int         restart_writes;
    logic       hold_done = 1'b0;   // Keeps the sample period open during host reads
    logic       last_info = 1'b0;   // Ack in flight closes the last status read
    logic [7:0] host_addrs [10] = '{8'h00, 8'h04, 8'h08, 8'h0C, 8'h10, 8'h14, 8'h18,
                                    8'h40, 8'h44, 8'h48};

    assign row_c = (row < N_ROWS) ? row : N_ROWS - 1;

    agc_loop_top agc_loop_top_i (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .agc_req_o(agc_req), .agc_rsp_i(agc_rsp),
        .host_req_i(host_req), .host_rsp_o(host_rsp)
    );

    agc_loop_checker checker_i (
        .aclk(aclk), .wb_rst_i(wb_rst_i), .agc_reset_i(agc_reset_i),
        .agc_req_i(agc_req), .agc_rsp_i(agc_rsp), .host_req_i(host_req),
        .host_rsp_i(host_rsp), .tbl_scale_i(rows[row_c].exp_scale),
        .tbl_offset_i(rows[row_c].exp_offset), .err_cnt_o(err_cnt),
        .test_cnt_o(test_cnt), .restart_writes_o(restart_writes)
    );

    initial begin
        forever #(CLK_NS / 2) aclk = ~aclk;
    end

    function automatic logic [31:0] read_word(input logic [7:0] adr);
        agc_word_u w;
        w.raw = '0;
        case (adr)
            8'h00: w.ctrl.done = (polls_left == 0) && !hold_done;
            8'h04: w.raw = rows[row_c].w1;
            8'h08: w.raw = rows[row_c].w2;
            8'h0C: w.raw = rows[row_c].w3;
            8'h10: w.raw = rows[row_c].w4;
            8'h14: w.raw = rows[row_c].w5;
            default: w.raw = '0;
        endcase
        return w.raw;
    endfunction

    ////////////////////////////////////////
    // Downstream AGC model
    ////////////////////////////////////////
    always @(negedge aclk) begin
        if (agc_rsp.ack) begin
            agc_rsp.ack = 1'b0;
            if (last_info) row++;  // Last status word read
        end else if (!agc_req.cyc) begin
            wait_cnt = 0;
        end else begin
            if (wait_cnt == 0) wait_cnt = 1 + int'($unsigned($random(seed)) % 4);
            wait_cnt--;
            if (wait_cnt == 0) begin
                agc_rsp.ack = 1'b1;
                agc_rsp.dat = agc_req.we ? 32'd0 : read_word(agc_req.adr);
                last_info = !agc_req.we && agc_req.adr == ADDR_OFFSET;
                if (agc_req.we && agc_req.adr == ADDR_CTRL && agc_req.dat == CMD_START) begin
                    polls_left = 2;
                    start_cnt++;
                end else if (!agc_req.we && agc_req.adr == ADDR_CTRL && polls_left > 0) begin
                    polls_left--;
                end
            end
        end
    end

    task automatic wait_for_start();
        int base;
        base = start_cnt;
        while (start_cnt == base) @(negedge aclk);
    endtask

    task automatic host_read(input logic [7:0] adr);
        int n;
        n = 0;
        @(negedge aclk);
        host_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0, sel: '1};
        while (!host_rsp.ack && n < 20) begin
            @(negedge aclk);
            n++;
        end
        if (!host_rsp.ack) begin
            $display("host read of 0x%02h got no ack", adr);
            tb_errs++;
        end
        host_req = '0;
    endtask

    initial begin
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        wb_rst_i = 1'b0;
        while (row < 3) @(negedge aclk);
        hold_done = 1'b1;
        wait_for_start();
        for (int i = 0; i < 10; i++) begin
            host_read(host_addrs[i]);
        end
        hold_done = 1'b0;
        while (row < N_ROWS) @(negedge aclk);
        wait_for_start();   // Reset lands in the middle of the polls
        agc_reset_i = 1'b1;
        repeat (2) @(negedge aclk);
        agc_reset_i = 1'b0;
        while (restart_writes < 4) @(negedge aclk);
        repeat (2) @(negedge aclk);
        $display("tests: %0d, errors: %0d", test_cnt, err_cnt + tb_errs);
        if (err_cnt + tb_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog sized from the number of table rows
    initial begin
        #((N_ROWS * 200 + 500) * CLK_NS);
        $display("run stopped by the watchdog before the tests finished");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: project.f
source/agc_bus_pkg.sv
source/agc_loop_pkg.sv
source/agc_bus_master.sv
source/agc_sequencer.sv
source/agc_update_calc.sv
source/agc_status_target.sv
source/agc_loop_top.sv
sim/agc_loop_checker.sv
sim/tb_agc_loop.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AGC loop testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_agc_loop \
    -f project.f -Mdir obj_dir -o tb_agc_loop > build.log 2>&1 \
    && ./obj_dir/tb_agc_loop > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
! grep -q "FAIL: see errors above" sim.log || { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation did not finish"; exit 1; }
